/* common/cmd_defines.svh */
`ifndef CMD_DEFINES_SVH
`define CMD_DEFINES_SVH

// Bus widths
`define CMD_ADDR_W 12 // 4096-word memory
`define CMD_DATA_W 32
`define CMD_OP_W   8

// Binary ops touch addr, addr+1 and addr+2
// First illegal start address for them
`define CMD_BIN_ADDR_LIMIT 12'hFFE

// Width of the two packed structs in cmd_pkg
`define CMD_FRAME_W (`CMD_ADDR_W + `CMD_OP_W + `CMD_DATA_W)
`define CMD_REQ_W   (`CMD_ADDR_W + `CMD_DATA_W + 2)

`endif

/* common/cmd_pkg.sv */
`default_nettype none

`include "cmd_defines.svh"

package cmd_pkg;

    // ------------------------------
    // Opcodes
    // ------------------------------
    typedef enum logic [`CMD_OP_W-1:0] {
        WRITE   = 8'h02, // Store frame data
        READ    = 8'h03, // Return memory word
        INC_ACC = 8'h06, // Word + 1, written back
        ADD     = 8'h10,
        SUB     = 8'h11, // A - B
        INV     = 8'h14, // ~word, written back
        AND     = 8'h15,
        OR      = 8'h16,
        XOR     = 8'h17
    } cmd_opcode_e;

    // How a command uses the memory
    typedef enum logic [2:0] {
        OPC_NOP    = 3'd0, // No access at all
        OPC_WRITE  = 3'd1, // Single write
        OPC_READ   = 3'd2, // Single read
        OPC_RMW    = 3'd3, // Read, then write-back
        OPC_BINARY = 3'd4  // Two reads, one write
    } op_class_e;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        DECODE     = 3'd1,
        EXECUTE    = 3'd2,
        MEM_ACCESS = 3'd3,
        WAIT       = 3'd4,
        DONE       = 3'd5
    } cmd_state_e;

    // ------------------------------
    // Frame and memory request
    // ------------------------------
    typedef struct packed {
        logic [`CMD_ADDR_W-1:0] addr;
        logic [`CMD_OP_W-1:0]   opcode; // Raw value, may be unknown
        logic [`CMD_DATA_W-1:0] wdata;
    } cmd_frame_t;

    typedef struct packed {
        logic [`CMD_ADDR_W-1:0] addr;
        logic [`CMD_DATA_W-1:0] wdata;
        logic                   wen; // Write when set, else read
        logic                   cen; // Access on this edge
    } mem_req_t;

endpackage

`default_nettype wire

/* ctrl/cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_defines.svh"

// Opcode classifier and address range check, purely combinational
module cmd_decode (
    input  cmd_pkg::cmd_opcode_e    opcode,
    input  logic [`CMD_ADDR_W-1:0]  addr,
    output cmd_pkg::op_class_e      op_class,
    output logic                    addr_error
);

    // ------------------------------
    // Memory usage per opcode
    // ------------------------------
    always_comb begin
        case (opcode)
            cmd_pkg::WRITE: op_class = cmd_pkg::OPC_WRITE;
            cmd_pkg::READ:  op_class = cmd_pkg::OPC_READ;

            // Read, modify, write back to same word
            cmd_pkg::INC_ACC,
            cmd_pkg::INV:   op_class = cmd_pkg::OPC_RMW;

            // Operands at addr and addr+1, result to addr+2
            cmd_pkg::ADD,
            cmd_pkg::SUB,
            cmd_pkg::AND,
            cmd_pkg::OR,
            cmd_pkg::XOR:   op_class = cmd_pkg::OPC_BINARY;

            default:        op_class = cmd_pkg::OPC_NOP; // Unknown opcode
        endcase
    end

    // ------------------------------
    // Range check
    // ------------------------------
    // Only binary ops span three words, everything else fits anywhere
    always_comb begin
        addr_error = (op_class == cmd_pkg::OPC_BINARY) &&
                     (addr >= `CMD_BIN_ADDR_LIMIT);
    end

endmodule

`default_nettype wire

/* ctrl/cmd_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_defines.svh"

// Command sequencer, one frame in flight
module cmd_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    frame_valid,
    input  cmd_pkg::cmd_frame_t     frame,
    input  cmd_pkg::op_class_e      op_class,
    input  logic                    addr_error,
    input  logic [`CMD_DATA_W-1:0]  mem_rdata,
    input  logic [`CMD_DATA_W-1:0]  alu_result,
    output logic                    frame_ready,
    output logic                    cmd_start,
    output logic                    cmd_busy,
    output logic [`CMD_DATA_W-1:0]  cmd_result,
    output logic                    cmd_result_valid,
    output logic                    cmd_error,
    output cmd_pkg::cmd_opcode_e    held_opcode,
    output logic [`CMD_ADDR_W-1:0]  held_addr,
    output logic [`CMD_DATA_W-1:0]  operand_a,
    output cmd_pkg::mem_req_t       mem_req
);

    cmd_pkg::cmd_state_e     state;
    cmd_pkg::cmd_state_e     state_nxt;
    cmd_pkg::cmd_frame_t     frame_q;     // Accepted frame
    logic [`CMD_DATA_W-1:0]  operand_a_q; // Word at addr, binary ops
    logic [`CMD_DATA_W-1:0]  result_q;
    logic                    result_valid_q;
    logic                    error_q;
    logic                    phase_q;     // 0 = operand A, 1 = operand B
    logic [`CMD_ADDR_W-1:0]  req_addr;
    logic [`CMD_DATA_W-1:0]  req_wdata;
    logic                    req_wen;
    logic                    req_cen;
    logic                    accept;
    logic                    is_binary;
    logic                    returns_result; // READ or RMW
    logic                    wb_now;         // WAIT issues a write

    assign accept         = (state == cmd_pkg::IDLE) && frame_valid;
    assign is_binary      = (op_class == cmd_pkg::OPC_BINARY);
    assign returns_result = (op_class == cmd_pkg::OPC_READ) ||
                            (op_class == cmd_pkg::OPC_RMW);
    // RMW write-back, or binary result once operand B is in
    assign wb_now = (state == cmd_pkg::WAIT) &&
                    ((op_class == cmd_pkg::OPC_RMW) || (is_binary && phase_q));

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            cmd_pkg::IDLE:       if (frame_valid) state_nxt = cmd_pkg::DECODE;
            cmd_pkg::DECODE: begin
                // Bad range or no-op skips memory entirely
                if (addr_error || (op_class == cmd_pkg::OPC_NOP)) begin
                    state_nxt = cmd_pkg::DONE;
                end else begin
                    state_nxt = cmd_pkg::EXECUTE;
                end
            end
            cmd_pkg::EXECUTE:    state_nxt = cmd_pkg::MEM_ACCESS;
            cmd_pkg::MEM_ACCESS: state_nxt = cmd_pkg::WAIT;
            cmd_pkg::WAIT: begin
                if (is_binary && !phase_q) begin
                    state_nxt = cmd_pkg::EXECUTE; // Go fetch operand B
                end else begin
                    state_nxt = cmd_pkg::DONE;
                end
            end
            cmd_pkg::DONE:       state_nxt = cmd_pkg::IDLE;
            default:             state_nxt = cmd_pkg::IDLE;
        endcase
    end

    // ------------------------------
    // Control registers
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= cmd_pkg::IDLE;
            result_valid_q <= 1'b0;
            error_q        <= 1'b0;
            phase_q        <= 1'b0;
            req_wen        <= 1'b0;
            req_cen        <= 1'b0;
        end else begin
            state <= state_nxt;
            case (state)
                cmd_pkg::IDLE: if (accept) error_q <= 1'b0; // Cleared by next frame
                cmd_pkg::DECODE: error_q <= addr_error;
                cmd_pkg::EXECUTE: begin
                    req_cen <= 1'b1;
                    req_wen <= (op_class == cmd_pkg::OPC_WRITE);
                end
                cmd_pkg::WAIT: begin
                    result_valid_q <= returns_result;
                    req_cen        <= wb_now;
                    req_wen        <= wb_now;
                    if (is_binary) phase_q <= ~phase_q; // Back to 0 after B
                end
                cmd_pkg::DONE: begin
                    result_valid_q <= 1'b0;
                    req_cen        <= 1'b0;
                    req_wen        <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    // ------------------------------
    // Payload registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (accept) frame_q <= frame;
        if (state == cmd_pkg::EXECUTE) begin
            req_addr  <= frame_q.addr + `CMD_ADDR_W'(phase_q); // addr or addr+1
            req_wdata <= frame_q.wdata;
        end
        if ((state == cmd_pkg::WAIT) && is_binary && !phase_q) operand_a_q <= mem_rdata;
        if ((state == cmd_pkg::WAIT) && returns_result) result_q <= alu_result;
        if (wb_now) begin
            req_addr  <= (op_class == cmd_pkg::OPC_RMW) ? frame_q.addr
                                                        : frame_q.addr + `CMD_ADDR_W'(2);
            req_wdata <= alu_result;
        end
    end

    // Outputs
    assign frame_ready      = (state == cmd_pkg::IDLE);
    assign cmd_start        = (state == cmd_pkg::DECODE);
    assign cmd_busy         = (state != cmd_pkg::IDLE);
    assign cmd_result       = result_q;
    assign cmd_result_valid = result_valid_q;
    assign cmd_error        = error_q;
    assign held_opcode      = cmd_pkg::cmd_opcode_e'(frame_q.opcode);
    assign held_addr        = frame_q.addr;
    assign operand_a        = operand_a_q;
    assign mem_req          = '{addr: req_addr, wdata: req_wdata, wen: req_wen, cen: req_cen};

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/cmd_pkg.sv
ctrl/cmd_decode.sv
ctrl/cmd_fsm.sv
src/cmd_alu.sv
src/cmd_controller.sv
tb/tb_clkgen.sv
tb/tb_mem_model.sv
tb/cmd_controller_assert.sv
tb/tb_cmd_controller.sv

/* src/cmd_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_defines.svh"

// Result unit for every command that transforms data
module cmd_alu (
    input  cmd_pkg::cmd_opcode_e    opcode,
    input  logic [`CMD_DATA_W-1:0]  operand_a,  // Registered word at addr
    input  logic [`CMD_DATA_W-1:0]  operand_b,  // Live memory read data
    output logic [`CMD_DATA_W-1:0]  alu_result
);

    // ------------------------------
    // Single-operand commands
    // ------------------------------
    logic [`CMD_DATA_W-1:0] inc_b;
    logic [`CMD_DATA_W-1:0] inv_b;

    assign inc_b = operand_b + `CMD_DATA_W'(1); // Wraps at all ones
    assign inv_b = ~operand_b;

    // ------------------------------
    // Result select
    // ------------------------------
    always_comb begin
        case (opcode)
            cmd_pkg::READ:    alu_result = operand_b; // Plain pass-through
            cmd_pkg::INC_ACC: alu_result = inc_b;
            cmd_pkg::INV:     alu_result = inv_b;

            // Two-operand ops, A from addr and B from addr+1
            cmd_pkg::ADD:     alu_result = operand_a + operand_b;
            cmd_pkg::SUB:     alu_result = operand_a - operand_b;
            cmd_pkg::AND:     alu_result = operand_a & operand_b;
            cmd_pkg::OR:      alu_result = operand_a | operand_b;
            cmd_pkg::XOR:     alu_result = operand_a ^ operand_b;

            // WRITE and unknown opcodes produce nothing
            default:          alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/cmd_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_defines.svh"

// Memory command controller top
module cmd_controller (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    frame_valid,
    input  cmd_pkg::cmd_frame_t     frame,
    input  logic [`CMD_DATA_W-1:0]  mem_rdata,
    output logic                    frame_ready,
    output logic                    cmd_start,
    output logic                    cmd_busy,
    output logic                    cmd_result_valid,
    output logic                    cmd_error,
    output logic [`CMD_DATA_W-1:0]  cmd_result,
    output cmd_pkg::mem_req_t       mem_req
);

    // ------------------------------
    // Internal nets
    // ------------------------------
    cmd_pkg::cmd_opcode_e    held_opcode; // Held frame to decoder and ALU
    logic [`CMD_ADDR_W-1:0]  held_addr;
    cmd_pkg::op_class_e      op_class;
    logic                    addr_error;
    logic [`CMD_DATA_W-1:0]  operand_a;
    logic [`CMD_DATA_W-1:0]  alu_result;

    cmd_fsm u_fsm (
        .clk              (clk),
        .rst_n            (rst_n),
        .frame_valid      (frame_valid),
        .frame            (frame),
        .op_class         (op_class),
        .addr_error       (addr_error),
        .mem_rdata        (mem_rdata),
        .alu_result       (alu_result),
        .frame_ready      (frame_ready),
        .cmd_start        (cmd_start),
        .cmd_busy         (cmd_busy),
        .cmd_result       (cmd_result),
        .cmd_result_valid (cmd_result_valid),
        .cmd_error        (cmd_error),
        .held_opcode      (held_opcode),
        .held_addr        (held_addr),
        .operand_a        (operand_a),
        .mem_req          (mem_req)
    );

    cmd_decode u_decode (
        .opcode     (held_opcode),
        .addr       (held_addr),
        .op_class   (op_class),
        .addr_error (addr_error)
    );

    // Operand B straight from memory read data
    cmd_alu u_alu (
        .opcode     (held_opcode),
        .operand_a  (operand_a),
        .operand_b  (mem_rdata),
        .alu_result (alu_result)
    );

endmodule

`default_nettype wire

/* tb/cmd_controller_assert.sv */
`timescale 1ns/1ps
`default_nettype none

// Port-level protocol properties, bound into cmd_controller
module cmd_controller_assert (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                frame_ready,
    input  logic                cmd_start,
    input  logic                cmd_busy,
    input  logic                cmd_result_valid,
    input  cmd_pkg::mem_req_t   mem_req
);

    int fail_count = 0; // Failed property count, checked at end of run

    // ------------------------------
    // Memory request
    // ------------------------------
    wen_needs_cen: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.wen |-> mem_req.cen)
        else begin
            $error("Write enable raised without chip enable");
            fail_count++;
        end

    // ------------------------------
    // Status outputs
    // ------------------------------
    ready_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        frame_ready |-> !cmd_busy)
        else begin
            $error("frame_ready high while cmd_busy is high");
            fail_count++;
        end

    start_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_start |=> !cmd_start) // DECODE lasts one cycle
        else begin
            $error("cmd_start held for more than one cycle");
            fail_count++;
        end

    valid_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_result_valid |-> cmd_busy)
        else begin
            $error("cmd_result_valid outside a busy command");
            fail_count++;
        end

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

// 10 ns clock, reset low for the first 4 rising edges
module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1; // Released just after the edge
    end

endmodule

`default_nettype wire

/* tb/tb_cmd_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_defines.svh"

module tb_cmd_controller;

    localparam int ROWS  = 20;
    localparam int LIMIT = ROWS * 12 + 50; // Binary ops need 8 busy cycles plus handoff

    logic                   clk;
    logic                   rst_n;
    logic                   frame_valid;
    cmd_pkg::cmd_frame_t    frame;
    logic [`CMD_DATA_W-1:0] mem_rdata;
    logic                   frame_ready;
    logic                   cmd_start;
    logic                   cmd_busy;
    logic                   cmd_result_valid;
    logic                   cmd_error;
    logic [`CMD_DATA_W-1:0] cmd_result;
    cmd_pkg::mem_req_t      mem_req;

    // Stimulus table, one entry per command
    string                  row_name  [ROWS];
    cmd_pkg::cmd_frame_t    row_frame [ROWS];
    logic                   row_err   [ROWS];
    logic                   row_rv    [ROWS];
    int                     n_rows    = 0;
    int                     cycle_cnt = 0;

    logic [`CMD_DATA_W-1:0] mirror [0:(1 << `CMD_ADDR_W) - 1]; // Expected memory

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cmd_controller UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .frame_valid      (frame_valid),
        .frame            (frame),
        .mem_rdata        (mem_rdata),
        .frame_ready      (frame_ready),
        .cmd_start        (cmd_start),
        .cmd_busy         (cmd_busy),
        .cmd_result_valid (cmd_result_valid),
        .cmd_error        (cmd_error),
        .cmd_result       (cmd_result),
        .mem_req          (mem_req)
    );

    tb_mem_model u_mem (
        .clk   (clk),
        .req   (mem_req),
        .rdata (mem_rdata)
    );

    bind cmd_controller cmd_controller_assert u_assert (
        .clk              (clk),
        .rst_n            (rst_n),
        .frame_ready      (frame_ready),
        .cmd_start        (cmd_start),
        .cmd_busy         (cmd_busy),
        .cmd_result_valid (cmd_result_valid),
        .mem_req          (mem_req)
    );

    // ------------------------------
    // Failure reporting
    // ------------------------------
    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("MISMATCH %s %s: expected %h, actual %h", name, what, exp, act);
        $display("STATUS: FAIL");
        $fatal(1, "Check failed in %s", name);
    endtask

    task automatic report_error(input string text);
        $display("ERROR: %s", text);
        $display("STATUS: FAIL");
        $fatal(1, "Check failed");
    endtask

    // ------------------------------
    // Table setup
    // ------------------------------
    task automatic add_row(input string name, input logic [7:0] op,
                           input logic [`CMD_ADDR_W-1:0] addr,
                           input logic [`CMD_DATA_W-1:0] wdata, input logic err, input logic rv);
        row_name[n_rows]  = name;
        row_frame[n_rows] = '{addr: addr, opcode: op, wdata: wdata};
        row_err[n_rows]   = err;
        row_rv[n_rows]    = rv;
        n_rows++;
    endtask

    task automatic build_table();
        logic [`CMD_ADDR_W-1:0] a;
        logic [7:0]             bin_ops   [5] = '{8'h10, 8'h11, 8'h15, 8'h16, 8'h17};
        string                  bin_names [5] = '{"add", "sub", "and", "or", "xor"};
        a = `CMD_ADDR_W'($urandom);
        add_row("write_rand", cmd_pkg::WRITE, a, $urandom, 1'b0, 1'b0);
        add_row("read_back", cmd_pkg::READ, a, '0, 1'b0, 1'b1);
        a = `CMD_ADDR_W'($urandom);
        add_row("inc_acc", cmd_pkg::INC_ACC, a, '0, 1'b0, 1'b1);
        add_row("read_inc", cmd_pkg::READ, a, '0, 1'b0, 1'b1);
        a = `CMD_ADDR_W'($urandom);
        add_row("inv", cmd_pkg::INV, a, '0, 1'b0, 1'b1);
        add_row("read_inv", cmd_pkg::READ, a, '0, 1'b0, 1'b1);
        for (int k = 0; k < 5; k++) begin
            a = `CMD_ADDR_W'($urandom % `CMD_BIN_ADDR_LIMIT); // Legal start only
            add_row(bin_names[k], bin_ops[k], a, '0, 1'b0, 1'b0);
            add_row({"read_", bin_names[k]}, cmd_pkg::READ, a + `CMD_ADDR_W'(2),
                    '0, 1'b0, 1'b1);
        end
        add_row("add_bad_addr", cmd_pkg::ADD, 12'hFFE, '0, 1'b1, 1'b0);
        add_row("read_wrap", cmd_pkg::READ, 12'h000, '0, 1'b0, 1'b1); // addr+2 wraps here
        add_row("read_ffe", cmd_pkg::READ, 12'hFFE, '0, 1'b0, 1'b1);
        add_row("unknown_op", 8'h55, `CMD_ADDR_W'($urandom), $urandom, 1'b0, 1'b0);
    endtask

    // ------------------------------
    // Reference behavior
    // ------------------------------
    function automatic int expected_cycles(input int i);
        if (row_err[i]) return 2; // DECODE then DONE
        case (row_frame[i].opcode)
            cmd_pkg::WRITE, cmd_pkg::READ, cmd_pkg::INC_ACC, cmd_pkg::INV: return 5;
            cmd_pkg::ADD, cmd_pkg::SUB, cmd_pkg::AND, cmd_pkg::OR, cmd_pkg::XOR: return 8;
            default: return 2;
        endcase
    endfunction

    task automatic apply_model(input int i, output logic [`CMD_DATA_W-1:0] res);
        logic [`CMD_ADDR_W-1:0] a;
        logic [`CMD_DATA_W-1:0] op_a;
        logic [`CMD_DATA_W-1:0] op_b;
        logic                   bin;
        a    = row_frame[i].addr;
        op_a = mirror[a];
        op_b = mirror[`CMD_ADDR_W'(a + 1)];
        res  = '0;
        bin  = 1'b0;
        if (!row_err[i]) begin
            case (row_frame[i].opcode)
                cmd_pkg::WRITE: mirror[a] = row_frame[i].wdata;
                cmd_pkg::READ:  res = op_a;
                cmd_pkg::INC_ACC: begin
                    res       = op_a + 1;
                    mirror[a] = res;
                end
                cmd_pkg::INV: begin
                    res       = ~op_a;
                    mirror[a] = res;
                end
                cmd_pkg::ADD: res = op_a + op_b;
                cmd_pkg::SUB: res = op_a - op_b; // A minus B
                cmd_pkg::AND: res = op_a & op_b;
                cmd_pkg::OR:  res = op_a | op_b;
                cmd_pkg::XOR: res = op_a ^ op_b;
                default: ;
            endcase
            bin = (expected_cycles(i) == 8);
            if (bin) mirror[`CMD_ADDR_W'(a + 2)] = res;
        end
    endtask

    // ------------------------------
    // One command, start to finish
    // ------------------------------
    task automatic run_row(input int i);
        logic [`CMD_DATA_W-1:0] exp_res;
        logic [`CMD_DATA_W-1:0] got_res;
        logic                   err_seen;
        int                     exp_busy;
        int                     busy_cnt;
        int                     start_cnt;
        int                     rv_cnt;
        int                     cen_cnt;
        exp_busy  = expected_cycles(i);
        apply_model(i, exp_res);
        got_res   = '0;
        err_seen  = 1'b0;
        busy_cnt  = 0;
        start_cnt = 0;
        rv_cnt    = 0;
        cen_cnt   = 0;
        @(negedge clk);
        while (!frame_ready) @(negedge clk);
        @(posedge clk);
        #1;
        frame_valid = 1'b1;
        frame       = row_frame[i];
        @(posedge clk); // Accepted here
        #1;
        frame_valid = 1'b0;
        @(negedge clk);
        while (cmd_busy) begin
            busy_cnt++;
            if (cmd_start) start_cnt++;
            if (mem_req.cen) cen_cnt++;
            if (cmd_result_valid) begin
                rv_cnt++;
                got_res = cmd_result;
            end
            err_seen = cmd_error; // Last sample is the DONE cycle
            @(negedge clk);
        end
        assert (busy_cnt == exp_busy)
            else report_mismatch(row_name[i], "busy cycles", exp_busy, busy_cnt);
        assert (start_cnt == 1)
            else report_mismatch(row_name[i], "cmd_start cycles", 1, start_cnt);
        assert (rv_cnt == int'(row_rv[i]))
            else report_mismatch(row_name[i], "result valid cycles", row_rv[i], rv_cnt);
        if (row_rv[i]) begin
            assert (got_res == exp_res)
                else report_mismatch(row_name[i], "cmd_result", exp_res, got_res);
        end
        assert (err_seen == row_err[i])
            else report_mismatch(row_name[i], "cmd_error in DONE", row_err[i], err_seen);
        assert (cmd_error == row_err[i])
            else report_mismatch(row_name[i], "cmd_error held", row_err[i], cmd_error);
        if (exp_busy == 2) begin
            assert (cen_cnt == 0)
                else report_error({row_name[i], " accessed memory but should not have"});
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [`CMD_DATA_W-1:0] w;
        frame_valid = 1'b0;
        frame       = '0;
        void'($urandom(31207));
        for (int j = 0; j < (1 << `CMD_ADDR_W); j++) begin
            w         = $urandom;
            mirror[j] = w;
            u_mem.load_word(`CMD_ADDR_W'(j), w);
        end
        build_table();
        @(posedge rst_n);
        @(negedge clk);
        assert (frame_ready && !cmd_busy && !cmd_result_valid && !cmd_error && !mem_req.cen)
            else report_error("status outputs not in their idle state after reset");
        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        if (UUT.u_assert.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("ERROR: %0d protocol assertion failures", UUT.u_assert.fail_count);
            $display("STATUS: FAIL");
            $fatal(1, "Protocol assertions failed");
        end
    end

    // Run length guard and protocol watch
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            $display("ERROR: timeout, the run went past %0d cycles", LIMIT);
            $display("STATUS: FAIL");
            $fatal(1, "Timeout");
        end else if (UUT.u_assert.fail_count != 0) begin
            report_error("a bound protocol assertion failed"); // Stop at the first one
        end
    end

endmodule

`default_nettype wire

/* tb/tb_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_defines.svh"

// Single-port synchronous memory, read data one cycle after the request
module tb_mem_model (
    input  logic                    clk,
    input  cmd_pkg::mem_req_t       req,
    output logic [`CMD_DATA_W-1:0]  rdata
);

    logic [`CMD_DATA_W-1:0] mem [0:(1 << `CMD_ADDR_W) - 1];

    always @(posedge clk) begin
        if (req.cen) begin
            if (req.wen) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rdata <= mem[req.addr]; // Valid in the next cycle
            end
        end
    end

    // Preload before reset ends
    task automatic load_word(input logic [`CMD_ADDR_W-1:0] addr,
                             input logic [`CMD_DATA_W-1:0] data);
        mem[addr] = data;
    endtask

endmodule

`default_nettype wire
